//--- logic/tcdm_params.svh
// Build constants for the cluster; only four groups and a queue depth of at least one are legal
`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// Number of groups, one bank and one requester each
`define TCDM_NUM_GROUPS 4

// Width of a data word
`define TCDM_DATA_W 32

// Row index inside one bank, 16 words per bank
`define TCDM_ROW_W 4

// Group id, also the width of a link direction
`define TCDM_GROUP_W 2

// Requester tag carried back with the response
`define TCDM_TAG_W 2

// Entries in each request queue
`define TCDM_QUEUE_DEPTH 2

`endif

//--- logic/tcdm_pkg.sv
// Shared types; word addresses interleave groups in the low bits, so consecutive words change bank
`default_nettype none
`include "tcdm_params.svh"

package tcdm_pkg;

  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [`TCDM_ROW_W-1:0] row_t;
  typedef logic [`TCDM_GROUP_W-1:0] group_id_t;

  // Target group in bits 1:0, row above it
  typedef logic [`TCDM_ROW_W+`TCDM_GROUP_W-1:0] addr_t;

  // Source group XOR target group, 0 is local
  typedef logic [`TCDM_GROUP_W-1:0] dir_t;

  typedef logic [`TCDM_TAG_W-1:0] tag_t;

  // Round-robin pick, first valid input at or after ptr
  function automatic dir_t rr_pick(input logic [`TCDM_NUM_GROUPS-1:0] valid, input dir_t ptr);
    dir_t idx;
    dir_t pick;
    pick = ptr;
    // Walk from the far end so the nearest valid input wins
    for (int i = `TCDM_NUM_GROUPS - 1; i >= 0; i--) begin
      idx = ptr + dir_t'(i);
      if (valid[idx]) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

endpackage : tcdm_pkg

`default_nettype wire

//--- logic/tcdm_req_port.sv
// Request queue of one group; only the head is offered, so a stalled bank also holds later requests
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_params.svh"

module tcdm_req_port (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  tcdm_pkg::group_id_t                         group_id_i,
  // Requester side
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  tcdm_pkg::addr_t                             req_addr_i,
  input  logic                                        req_wen_i,
  input  tcdm_pkg::data_t                             req_wdata_i,
  input  tcdm_pkg::tag_t                              req_tag_i,
  // One link per direction
  output logic            [`TCDM_NUM_GROUPS-1:0]      link_valid_o,
  input  logic            [`TCDM_NUM_GROUPS-1:0]      link_ready_i,
  output tcdm_pkg::row_t  [`TCDM_NUM_GROUPS-1:0]      link_row_o,
  output logic            [`TCDM_NUM_GROUPS-1:0]      link_wen_o,
  output tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0]      link_wdata_o,
  output tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0]      link_tag_o
);

  localparam int unsigned DEPTH = `TCDM_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  tcdm_pkg::addr_t q_addr [DEPTH];
  logic            q_wen [DEPTH];
  tcdm_pkg::data_t q_wdata [DEPTH];
  tcdm_pkg::tag_t  q_tag [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             not_empty;
  logic             push;
  logic             pop;
  tcdm_pkg::addr_t  head_addr;
  tcdm_pkg::dir_t   head_dir;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign req_ready_o = (count_q != CNT_W'(DEPTH));
  assign push        = req_valid_i && req_ready_o;
  assign not_empty   = (count_q != '0);

  // Head decode, link direction from the target group field
  assign head_addr = q_addr[rd_ptr_q];
  assign head_dir  = head_addr[`TCDM_GROUP_W-1:0] ^ group_id_i;
  assign pop       = not_empty && link_ready_i[head_dir];

  always_comb begin
    for (int d = 0; d < `TCDM_NUM_GROUPS; d++) begin
      link_valid_o[d] = not_empty && (head_dir == tcdm_pkg::dir_t'(d));
      link_row_o[d]   = head_addr[`TCDM_ROW_W+`TCDM_GROUP_W-1:`TCDM_GROUP_W];
      link_wen_o[d]   = q_wen[rd_ptr_q];
      link_wdata_o[d] = q_wdata[rd_ptr_q];
      link_tag_o[d]   = q_tag[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_addr[wr_ptr_q]  <= req_addr_i;
      q_wen[wr_ptr_q]   <= req_wen_i;
      q_wdata[wr_ptr_q] <= req_wdata_i;
      q_tag[wr_ptr_q]   <= req_tag_i;
    end
  end

endmodule : tcdm_req_port

`default_nettype wire

//--- logic/tcdm_bank_node.sv
// Bank of one group; one grant per cycle and no new grant until the pending response is taken
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_params.svh"

module tcdm_bank_node (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  tcdm_pkg::group_id_t                    group_id_i,
  // Request links, indexed by arrival direction
  input  logic            [`TCDM_NUM_GROUPS-1:0] link_valid_i,
  output logic            [`TCDM_NUM_GROUPS-1:0] link_ready_o,
  input  tcdm_pkg::row_t  [`TCDM_NUM_GROUPS-1:0] link_row_i,
  input  logic            [`TCDM_NUM_GROUPS-1:0] link_wen_i,
  input  tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0] link_wdata_i,
  input  tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0] link_tag_i,
  // Response links, same direction as the request came in on
  output logic            [`TCDM_NUM_GROUPS-1:0] rsp_valid_o,
  input  logic            [`TCDM_NUM_GROUPS-1:0] rsp_ready_i,
  output tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0] rsp_rdata_o,
  output tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0] rsp_tag_o
);

  localparam int unsigned NUM_ROWS = 2 ** `TCDM_ROW_W;

  tcdm_pkg::data_t bank_q [NUM_ROWS];

  // Arbiter
  tcdm_pkg::dir_t  rr_ptr_q;
  tcdm_pkg::dir_t  winner;
  logic            any_valid;
  logic            can_grant;
  logic            grant;

  // Granted request
  tcdm_pkg::row_t  g_row;
  logic            g_wen;
  tcdm_pkg::data_t g_wdata;
  tcdm_pkg::tag_t  g_tag;

  // Response register
  logic            rsp_valid_q;
  tcdm_pkg::data_t rsp_rdata_q;
  tcdm_pkg::tag_t  rsp_tag_q;
  tcdm_pkg::dir_t  rsp_dir_q;
  logic            rsp_fire;

  assign any_valid = |link_valid_i;
  assign winner    = tcdm_pkg::rr_pick(link_valid_i, rr_ptr_q);

  // A response leaving on this edge frees the register for the next grant
  assign rsp_fire  = rsp_valid_q && rsp_ready_i[rsp_dir_q];
  assign can_grant = !rsp_valid_q || rsp_fire;
  assign grant     = can_grant && any_valid;

  assign g_row   = link_row_i[winner];
  assign g_wen   = link_wen_i[winner];
  assign g_wdata = link_wdata_i[winner];
  assign g_tag   = link_tag_i[winner];

  always_comb begin
    for (int d = 0; d < `TCDM_NUM_GROUPS; d++) begin
      link_ready_o[d] = grant && (winner == tcdm_pkg::dir_t'(d));
      rsp_valid_o[d]  = rsp_valid_q && (rsp_dir_q == tcdm_pkg::dir_t'(d));
      rsp_rdata_o[d]  = rsp_rdata_q;
      rsp_tag_o[d]    = rsp_tag_q;
    end
  end

  // Pointer starts at the group id so the four banks begin with different favourites
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q    <= group_id_i;
      rsp_valid_q <= 1'b0;
    end else begin
      if (grant) begin
        rr_ptr_q    <= winner + 1'b1;
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Register file, cleared to zero by reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        bank_q[r] <= '0;
      end
    end else if (grant && g_wen) begin
      bank_q[g_row] <= g_wdata;
    end
  end

  // Read data sampled on the grant edge, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (grant) begin
      rsp_rdata_q <= g_wen ? '0 : bank_q[g_row];
      rsp_tag_q   <= g_tag;
      // Source is this group XOR winner, so the return link index is winner itself
      rsp_dir_q   <= winner;
    end
  end

endmodule : tcdm_bank_node

`default_nettype wire

//--- logic/tcdm_resp_port.sv
// Response collector of one group; one output register, responses leave in arbitration order
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_params.svh"

module tcdm_resp_port (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  // Response links from the four banks, indexed by direction
  input  logic            [`TCDM_NUM_GROUPS-1:0] rsp_valid_i,
  output logic            [`TCDM_NUM_GROUPS-1:0] rsp_ready_o,
  input  tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0] rsp_rdata_i,
  input  tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0] rsp_tag_i,
  // Requester side
  output logic                                   resp_valid_o,
  input  logic                                   resp_ready_i,
  output tcdm_pkg::data_t                        resp_rdata_o,
  output tcdm_pkg::tag_t                         resp_tag_o
);

  tcdm_pkg::dir_t  rr_ptr_q;
  tcdm_pkg::dir_t  winner;
  logic            any_valid;
  logic            can_load;
  logic            load;

  logic            out_valid_q;
  tcdm_pkg::data_t out_rdata_q;
  tcdm_pkg::tag_t  out_tag_q;

  assign any_valid = |rsp_valid_i;
  assign winner    = tcdm_pkg::rr_pick(rsp_valid_i, rr_ptr_q);

  // Empty, or being emptied on this edge
  assign can_load = !out_valid_q || resp_ready_i;
  assign load     = can_load && any_valid;

  always_comb begin
    for (int d = 0; d < `TCDM_NUM_GROUPS; d++) begin
      rsp_ready_o[d] = load && (winner == tcdm_pkg::dir_t'(d));
    end
  end

  assign resp_valid_o = out_valid_q;
  assign resp_rdata_o = out_rdata_q;
  assign resp_tag_o   = out_tag_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (load) begin
        rr_ptr_q    <= winner + 1'b1;
        out_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Held while the requester stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      out_rdata_q <= rsp_rdata_i[winner];
      out_tag_q   <= rsp_tag_i[winner];
    end
  end

endmodule : tcdm_resp_port

`default_nettype wire

//--- logic/tcdm_cluster.sv
// Four-group cluster only; each port array is indexed by group id, link d joins g and g XOR d
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_params.svh"

module tcdm_cluster (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  // Request channels
  input  logic            [`TCDM_NUM_GROUPS-1:0] req_valid_i,
  output logic            [`TCDM_NUM_GROUPS-1:0] req_ready_o,
  input  tcdm_pkg::addr_t [`TCDM_NUM_GROUPS-1:0] req_addr_i,
  input  logic            [`TCDM_NUM_GROUPS-1:0] req_wen_i,
  input  tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0] req_wdata_i,
  input  tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0] req_tag_i,
  // Response channels
  output logic            [`TCDM_NUM_GROUPS-1:0] resp_valid_o,
  input  logic            [`TCDM_NUM_GROUPS-1:0] resp_ready_i,
  output tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0] resp_rdata_o,
  output tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0] resp_tag_o
);

  localparam int unsigned NG = `TCDM_NUM_GROUPS;

  // Request links at the source, [group][direction]
  logic            [NG-1:0][NG-1:0] rq_valid;
  logic            [NG-1:0][NG-1:0] rq_ready;
  tcdm_pkg::row_t  [NG-1:0][NG-1:0] rq_row;
  logic            [NG-1:0][NG-1:0] rq_wen;
  tcdm_pkg::data_t [NG-1:0][NG-1:0] rq_wdata;
  tcdm_pkg::tag_t  [NG-1:0][NG-1:0] rq_tag;

  // Request links at the bank, [bank][direction]
  logic            [NG-1:0][NG-1:0] bk_valid;
  logic            [NG-1:0][NG-1:0] bk_ready;
  tcdm_pkg::row_t  [NG-1:0][NG-1:0] bk_row;
  logic            [NG-1:0][NG-1:0] bk_wen;
  tcdm_pkg::data_t [NG-1:0][NG-1:0] bk_wdata;
  tcdm_pkg::tag_t  [NG-1:0][NG-1:0] bk_tag;

  // Response links leaving the bank
  logic            [NG-1:0][NG-1:0] bk_rsp_valid;
  logic            [NG-1:0][NG-1:0] bk_rsp_ready;
  tcdm_pkg::data_t [NG-1:0][NG-1:0] bk_rsp_rdata;
  tcdm_pkg::tag_t  [NG-1:0][NG-1:0] bk_rsp_tag;

  // Response links arriving at the requester's group
  logic            [NG-1:0][NG-1:0] rp_valid;
  logic            [NG-1:0][NG-1:0] rp_ready;
  tcdm_pkg::data_t [NG-1:0][NG-1:0] rp_rdata;
  tcdm_pkg::tag_t  [NG-1:0][NG-1:0] rp_tag;

  for (genvar g = 0; g < NG; g++) begin : gen_groups
    tcdm_req_port u_req_port (
      .clk_i        (clk_i                       ),
      .reset_i      (reset_i                     ),
      .group_id_i   (tcdm_pkg::group_id_t'(g)    ),
      .req_valid_i  (req_valid_i[g]              ),
      .req_ready_o  (req_ready_o[g]              ),
      .req_addr_i   (req_addr_i[g]               ),
      .req_wen_i    (req_wen_i[g]                ),
      .req_wdata_i  (req_wdata_i[g]              ),
      .req_tag_i    (req_tag_i[g]                ),
      .link_valid_o (rq_valid[g]                 ),
      .link_ready_i (rq_ready[g]                 ),
      .link_row_o   (rq_row[g]                   ),
      .link_wen_o   (rq_wen[g]                   ),
      .link_wdata_o (rq_wdata[g]                 ),
      .link_tag_o   (rq_tag[g]                   )
    );

    tcdm_bank_node u_bank_node (
      .clk_i        (clk_i                       ),
      .reset_i      (reset_i                     ),
      .group_id_i   (tcdm_pkg::group_id_t'(g)    ),
      .link_valid_i (bk_valid[g]                 ),
      .link_ready_o (bk_ready[g]                 ),
      .link_row_i   (bk_row[g]                   ),
      .link_wen_i   (bk_wen[g]                   ),
      .link_wdata_i (bk_wdata[g]                 ),
      .link_tag_i   (bk_tag[g]                   ),
      .rsp_valid_o  (bk_rsp_valid[g]             ),
      .rsp_ready_i  (bk_rsp_ready[g]             ),
      .rsp_rdata_o  (bk_rsp_rdata[g]             ),
      .rsp_tag_o    (bk_rsp_tag[g]               )
    );

    tcdm_resp_port u_resp_port (
      .clk_i        (clk_i                       ),
      .reset_i      (reset_i                     ),
      .rsp_valid_i  (rp_valid[g]                 ),
      .rsp_ready_o  (rp_ready[g]                 ),
      .rsp_rdata_i  (rp_rdata[g]                 ),
      .rsp_tag_i    (rp_tag[g]                   ),
      .resp_valid_o (resp_valid_o[g]             ),
      .resp_ready_i (resp_ready_i[g]             ),
      .resp_rdata_o (resp_rdata_o[g]             ),
      .resp_tag_o   (resp_tag_o[g]               )
    );
  end : gen_groups

  // Direction 0 local, 1 east, 2 north, 3 northeast
  for (genvar g = 0; g < NG; g++) begin : gen_links
    for (genvar d = 0; d < NG; d++) begin : gen_dir
      assign bk_valid[g ^ d][d] = rq_valid[g][d];
      assign bk_row[g ^ d][d]   = rq_row[g][d];
      assign bk_wen[g ^ d][d]   = rq_wen[g][d];
      assign bk_wdata[g ^ d][d] = rq_wdata[g][d];
      assign bk_tag[g ^ d][d]   = rq_tag[g][d];
      assign rq_ready[g][d]     = bk_ready[g ^ d][d];

      // Bank g answers on the direction the request arrived on
      assign rp_valid[g ^ d][d] = bk_rsp_valid[g][d];
      assign rp_rdata[g ^ d][d] = bk_rsp_rdata[g][d];
      assign rp_tag[g ^ d][d]   = bk_rsp_tag[g][d];
      assign bk_rsp_ready[g][d] = rp_ready[g ^ d][d];
    end : gen_dir
  end : gen_links

  if (NG != 4) begin : gen_chk_groups
    $fatal(1, "[tcdm_cluster] The cluster only works with four groups.");
  end

  if (`TCDM_QUEUE_DEPTH < 1) begin : gen_chk_depth
    $fatal(1, "[tcdm_cluster] The request queue needs at least one entry.");
  end

endmodule : tcdm_cluster

`default_nettype wire

//--- verif/tcdm_cluster_sva.sv
// Checks for the cluster boundary and bank grants; assumes exactly four groups, bound into tcdm_cluster
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_params.svh"

module tcdm_cluster_sva (
  input logic                                                 clk_i,
  input logic                                                 reset_i,
  input logic            [`TCDM_NUM_GROUPS-1:0]               resp_valid_o,
  input logic            [`TCDM_NUM_GROUPS-1:0]               resp_ready_i,
  input tcdm_pkg::data_t [`TCDM_NUM_GROUPS-1:0]               resp_rdata_o,
  input tcdm_pkg::tag_t  [`TCDM_NUM_GROUPS-1:0]               resp_tag_o,
  input logic  [`TCDM_NUM_GROUPS-1:0][`TCDM_NUM_GROUPS-1:0]   bank_link_valid_i,
  input logic  [`TCDM_NUM_GROUPS-1:0][`TCDM_NUM_GROUPS-1:0]   bank_link_ready_i,
  input logic  [`TCDM_NUM_GROUPS-1:0][`TCDM_NUM_GROUPS-1:0]   bank_rsp_valid_i
);

  for (genvar g = 0; g < `TCDM_NUM_GROUPS; g++) begin : gen_grp
    // Stalled response holds valid and payload
    assert property (@(posedge clk_i) disable iff (reset_i)
      resp_valid_o[g] && !resp_ready_i[g] |=>
        resp_valid_o[g] && $stable(resp_rdata_o[g]) && $stable(resp_tag_o[g]))
      else $error("response of group %0d changed while stalled", g);

    assert property (@(posedge clk_i) reset_i |=> !resp_valid_o[g])
      else $error("response of group %0d valid right after reset", g);

    // One accepted link request per bank and cycle, answered on its own link next cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
      |(bank_link_valid_i[g] & bank_link_ready_i[g]) |=>
        (bank_rsp_valid_i[g] == $past(bank_link_valid_i[g] & bank_link_ready_i[g])))
      else $error("bank %0d accepted more than one request or answered on another link", g);
  end : gen_grp

endmodule : tcdm_cluster_sva

bind tcdm_cluster tcdm_cluster_sva u_tcdm_cluster_sva (
  .clk_i             (clk_i       ),
  .reset_i           (reset_i     ),
  .resp_valid_o      (resp_valid_o),
  .resp_ready_i      (resp_ready_i),
  .resp_rdata_o      (resp_rdata_o),
  .resp_tag_o        (resp_tag_o  ),
  .bank_link_valid_i (bk_valid    ),
  .bank_link_ready_i (bk_ready    ),
  .bank_rsp_valid_i  (bk_rsp_valid)
);

`default_nettype wire

//--- verif/tcdm_cluster_tb.sv
// Cluster testbench; stimulus table must avoid cross-group hazards between drain points
`timescale 1ns/1ps
`default_nettype none
`include "tcdm_params.svh"

module tcdm_cluster_tb;

  localparam int NG          = `TCDM_NUM_GROUPS;
  localparam int NUM_TAGS    = 2 ** `TCDM_TAG_W;
  localparam int NUM_WORDS   = 2 ** (`TCDM_ROW_W + `TCDM_GROUP_W);
  localparam int SWEEP_REQS  = NUM_WORDS * NG;
  localparam int STALL_LIMIT = 16;

  // join_prev issues in the same cycle as the entry before it
  typedef struct packed {
    logic                join_prev;
    logic                drain;
    logic                timed;
    logic                bp;
    tcdm_pkg::group_id_t grp;
    tcdm_pkg::addr_t     addr;
    logic                wen;
    tcdm_pkg::data_t     wdata;
    tcdm_pkg::tag_t      tag;
  } stim_t;

  logic                       clk_i;
  logic                       reset_i;
  logic            [NG-1:0]   req_valid_i;
  logic            [NG-1:0]   req_ready_o;
  tcdm_pkg::addr_t [NG-1:0]   req_addr_i;
  logic            [NG-1:0]   req_wen_i;
  tcdm_pkg::data_t [NG-1:0]   req_wdata_i;
  tcdm_pkg::tag_t  [NG-1:0]   req_tag_i;
  logic            [NG-1:0]   resp_valid_o;
  logic            [NG-1:0]   resp_ready_i;
  tcdm_pkg::data_t [NG-1:0]   resp_rdata_o;
  tcdm_pkg::tag_t  [NG-1:0]   resp_tag_o;

  stim_t           stim_q [$];
  stim_t           batch_q [$];
  tcdm_pkg::data_t shadow [NUM_WORDS];
  logic            exp_busy [NG][NUM_TAGS];
  tcdm_pkg::data_t exp_data [NG][NUM_TAGS];
  int              seed = 32'h519927da;
  logic            bp_en;
  logic            stall;
  logic            saw_full;
  int              stall_cycles;

  tcdm_cluster u_tcdm_cluster (
    .clk_i        (clk_i       ),
    .reset_i      (reset_i     ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_addr_i   (req_addr_i  ),
    .req_wen_i    (req_wen_i   ),
    .req_wdata_i  (req_wdata_i ),
    .req_tag_i    (req_tag_i   ),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_tag_o   (resp_tag_o  )
  );

  always #50 clk_i = ~clk_i;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input tcdm_pkg::data_t got,
                            input tcdm_pkg::data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input tcdm_pkg::tag_t got,
                           input tcdm_pkg::tag_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp));
    end
  endtask

  function automatic stim_t make_stim(input logic join_prev, input logic drain,
                                      input logic timed, input logic bp, input int grp,
                                      input int addr, input logic wen,
                                      input tcdm_pkg::data_t wdata, input int tag);
    stim_t e;
    e.join_prev = join_prev;
    e.drain     = drain;
    e.timed     = timed;
    e.bp        = bp;
    e.grp       = tcdm_pkg::group_id_t'(grp);
    e.addr      = tcdm_pkg::addr_t'(addr);
    e.wen       = wen;
    e.wdata     = wdata;
    e.tag       = tcdm_pkg::tag_t'(tag);
    return e;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int g = 0; g < NG; g++) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        if (exp_busy[g][t]) begin
          n++;
        end
      end
    end
    return n;
  endfunction

  // Expected result taken from the shadow memory at acceptance
  task automatic record(input stim_t e);
    if (e.wen) begin
      shadow[e.addr] = e.wdata;
      exp_data[e.grp][e.tag] = '0;
    end else begin
      exp_data[e.grp][e.tag] = shadow[e.addr];
    end
    exp_busy[e.grp][e.tag] = 1'b1;
  endtask

  task automatic issue_batch();
    logic [NG-1:0] pending;
    logic [NG-1:0] fired;
    foreach (batch_q[i]) begin
      while (exp_busy[batch_q[i].grp][batch_q[i].tag]) begin
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    #5;
    pending = '0;
    foreach (batch_q[i]) begin
      req_valid_i[batch_q[i].grp] = 1'b1;
      req_addr_i[batch_q[i].grp]  = batch_q[i].addr;
      req_wen_i[batch_q[i].grp]   = batch_q[i].wen;
      req_wdata_i[batch_q[i].grp] = batch_q[i].wdata;
      req_tag_i[batch_q[i].grp]   = batch_q[i].tag;
      pending[batch_q[i].grp]     = 1'b1;
    end
    while (pending != '0) begin
      // Mid-cycle values are the ones seen at the next edge
      @(negedge clk_i);
      fired = pending & req_ready_o;
      foreach (batch_q[i]) begin
        if (fired[batch_q[i].grp]) begin
          record(batch_q[i]);
        end
      end
      @(posedge clk_i);
      #5;
      req_valid_i = req_valid_i & ~fired;
      pending     = pending & ~fired;
    end
  endtask

  task automatic drain();
    while (outstanding() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Idle cluster, so the response must be seen at the third edge after acceptance
  task automatic check_latency(input stim_t e, input tcdm_pkg::data_t exp);
    for (int c = 1; c <= 3; c++) begin
      @(negedge clk_i);
      if (c < 3 && resp_valid_o[e.grp]) begin
        stop_run($sformatf("group %0d response came after only %0d cycles", e.grp, c));
      end
    end
    if (!resp_valid_o[e.grp]) begin
      stop_run($sformatf("group %0d response missing three cycles after acceptance", e.grp));
    end
    check_tag($sformatf("resp_tag_o[%0d]", e.grp), resp_tag_o[e.grp], e.tag);
    check_data($sformatf("resp_rdata_o[%0d]", e.grp), resp_rdata_o[e.grp], exp);
  endtask

  task automatic add_stim(input logic join_prev, input logic drain, input logic timed,
                          input logic bp, input int grp, input int addr, input logic wen,
                          input tcdm_pkg::data_t wdata, input int tag);
    stim_q.push_back(make_stim(join_prev, drain, timed, bp, grp, addr, wen, wdata, tag));
  endtask

  task automatic build_table();
    // Local write then timed read
    add_stim(0, 1, 0, 0, 0, 6'h04, 1, 32'hA5A5_0001, 0);
    add_stim(0, 1, 1, 0, 0, 6'h04, 0, '0, 1);
    // Northeast write, read back over north and east
    add_stim(0, 1, 0, 0, 2, 6'h0d, 1, 32'h1234_5678, 0);
    add_stim(0, 1, 1, 0, 3, 6'h0d, 0, '0, 2);
    add_stim(0, 1, 1, 0, 0, 6'h0d, 0, '0, 3);
    add_stim(0, 1, 0, 0, 1, 6'h22, 1, 32'hCAFE_0003, 1);
    add_stim(0, 1, 1, 0, 3, 6'h22, 0, '0, 1);
    // All groups hit bank 2 at once
    add_stim(0, 1, 0, 0, 0, 6'h02, 1, 32'h0000_1002, 0);
    add_stim(1, 0, 0, 0, 1, 6'h06, 1, 32'h1111_1006, 0);
    add_stim(1, 0, 0, 0, 2, 6'h0a, 1, 32'h2222_100a, 0);
    add_stim(1, 0, 0, 0, 3, 6'h0e, 1, 32'h3333_100e, 0);
    add_stim(0, 1, 0, 0, 0, 6'h0e, 0, '0, 1);
    add_stim(1, 0, 0, 0, 1, 6'h0a, 0, '0, 1);
    add_stim(1, 0, 0, 0, 2, 6'h06, 0, '0, 1);
    add_stim(1, 0, 0, 0, 3, 6'h02, 0, '0, 1);
    add_stim(0, 0, 0, 0, 0, 6'h02, 0, '0, 2);
    add_stim(1, 0, 0, 0, 1, 6'h02, 0, '0, 2);
    add_stim(1, 0, 0, 0, 2, 6'h02, 0, '0, 2);
    add_stim(1, 0, 0, 0, 3, 6'h02, 0, '0, 2);
    // Back-pressure, group 0 fills its queue toward bank 0
    add_stim(0, 1, 0, 1, 0, 6'h10, 1, 32'hBEEF_0010, 0);
    add_stim(0, 0, 0, 1, 0, 6'h14, 1, 32'hBEEF_0014, 1);
    add_stim(0, 0, 0, 1, 0, 6'h10, 0, '0, 2);
    add_stim(0, 0, 0, 1, 0, 6'h14, 0, '0, 3);
    add_stim(0, 0, 0, 1, 0, 6'h14, 0, '0, 0);
    add_stim(1, 0, 0, 1, 1, 6'h30, 1, 32'h7777_0030, 2);
    add_stim(1, 0, 0, 1, 2, 6'h20, 0, '0, 0);
    add_stim(1, 0, 0, 1, 3, 6'h24, 0, '0, 0);
    add_stim(0, 0, 0, 1, 1, 6'h30, 0, '0, 3);
  endtask

  // Response scoreboard, matched by tag
  always @(negedge clk_i) begin : monitor
    tcdm_pkg::tag_t tg;
    if (!reset_i) begin
      for (int g = 0; g < NG; g++) begin
        if (resp_valid_o[g] && resp_ready_i[g]) begin
          tg = resp_tag_o[g];
          if (!exp_busy[g][tg]) begin
            stop_run($sformatf("group %0d returned tag %0d with no request outstanding", g, tg));
          end
          check_data($sformatf("resp_rdata_o[%0d]", g), resp_rdata_o[g], exp_data[g][tg]);
          exp_busy[g][tg] = 1'b0;
        end
      end
    end
  end

  // Responses stay stalled until a queue is seen full, or for a bounded time
  always @(negedge clk_i) begin : full_watch
    if (stall) begin
      stall_cycles++;
      saw_full = saw_full || (req_ready_o != '1);
      stall    = !saw_full && (stall_cycles < STALL_LIMIT);
    end
  end

  always @(posedge clk_i) begin : ready_drive
    int rnd;
    #5;
    for (int g = 0; g < NG; g++) begin
      rnd = $random(seed);
      resp_ready_i[g] = stall ? 1'b0 : (bp_en ? rnd[0] : 1'b1);
    end
  end

  initial begin : watchdog
    int limit;
    #1;
    limit = (stim_q.size() + SWEEP_REQS) * 40;
    repeat (limit) @(posedge clk_i);
    stop_run("watchdog expired before all responses came back");
  end

  initial begin : main
    stim_t           e;
    tcdm_pkg::data_t exp;
    int              i;
    logic            bp_seen;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_tag_i    = '0;
    resp_ready_i = '1;
    bp_en        = 1'b0;
    stall        = 1'b0;
    saw_full     = 1'b0;
    stall_cycles = 0;
    bp_seen      = 1'b0;
    for (int a = 0; a < NUM_WORDS; a++) begin
      shadow[a] = '0;
    end
    for (int g = 0; g < NG; g++) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        exp_busy[g][t] = 1'b0;
      end
    end
    build_table();
    repeat (2) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    @(negedge clk_i);
    if (req_ready_o != '1 || resp_valid_o != '0) begin
      stop_run("ports not idle after reset");
    end
    // Every group reads every word, expecting zero
    for (int a = 0; a < NUM_WORDS; a++) begin
      batch_q.delete();
      for (int g = 0; g < NG; g++) begin
        batch_q.push_back(make_stim(1'b0, 1'b0, 1'b0, 1'b0, g, a, 1'b0, '0, a % NUM_TAGS));
      end
      issue_batch();
    end
    i = 0;
    while (i < stim_q.size()) begin
      e = stim_q[i];
      if (e.drain) begin
        drain();
      end
      bp_en = e.bp;
      if (e.bp && !bp_seen) begin
        stall   = 1'b1;
        bp_seen = 1'b1;
      end
      batch_q.delete();
      batch_q.push_back(e);
      i++;
      while (i < stim_q.size() && stim_q[i].join_prev) begin
        batch_q.push_back(stim_q[i]);
        i++;
      end
      issue_batch();
      if (e.timed) begin
        exp = e.wen ? '0 : shadow[e.addr];
        check_latency(e, exp);
      end
    end
    drain();
    if (!saw_full) begin
      $display("request queue never filled under back-pressure");
      $display("Simulation FAILED");
      $fatal(1, "queue full condition not reached");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule : tcdm_cluster_tb

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/tcdm_pkg.sv
logic/tcdm_req_port.sv
logic/tcdm_bank_node.sv
logic/tcdm_resp_port.sv
logic/tcdm_cluster.sv
verif/tcdm_cluster_sva.sv
verif/tcdm_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cluster testbench with Verilator and runs it.
# The exit status is the simulator's: non-zero when a check or an assertion failed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f vlog.f \
  --top-module tcdm_cluster_tb \
  -Mdir obj_dir \
  -o sim_tcdm
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tcdm
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation run ended with status $status"
  exit "$status"
fi

exit 0
